//--- list.f
+incdir+hdl
hdl/midi_pkg.sv
hdl/midi_uart_rx.sv
hdl/midi_data_len_lookup.sv
hdl/midi_msg_capture.sv
hdl/midi_msg_merge.sv
hdl/midi_merge_top.sv
tb/midi_merge_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MIDI merger testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module midi_merge_tb -o midi_merge_sim \
    && ./obj_dir/midi_merge_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^all tests passed$" sim.log && exit 0 || exit 1

//--- tb/midi_merge_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_params.svh"

module midi_merge_tb;

    localparam int FRAME_CYCLES = 10 * `MIDI_CLKS_PER_BIT;
    localparam int TEST_CYCLES = 62 * FRAME_CYCLES;    // Worst case over all tests
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                  clk;
    logic                  reset;
    logic                  midi_in0;
    logic                  midi_in1;
    logic                  event_valid;
    midi_pkg::midi_event_t event_out;

    midi_pkg::midi_msg_t exp_q0[$];
    midi_pkg::midi_msg_t exp_q1[$];
    midi_pkg::midi_msg_t expected_msg;
    int                  mismatch_count;
    int                  failure_count;
    int                  event_count;
    int                  cycle_count;
    logic [31:0]         lfsr_state;

    midi_merge_top u_midi_merge_top (
        .clk         (clk),
        .reset       (reset),
        .midi_in0    (midi_in0),
        .midi_in1    (midi_in1),
        .event_valid (event_valid),
        .event_out   (event_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int expected_len(input midi_pkg::midi_byte_t s);
        case (s[7:4])
            4'h8, 4'h9, 4'hA, 4'hB, 4'hE: return 2;
            4'hC, 4'hD:                   return 1;
            4'hF: return (s == 8'hF2) ? 2 : ((s == 8'hF1 || s == 8'hF3) ? 1 : 0);
            default:                      return 0;
        endcase
    endfunction

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input midi_pkg::port_t port, input midi_pkg::midi_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            if (port == 1'b0) midi_in0 = frame[i];
            else midi_in1 = frame[i];
            repeat (`MIDI_CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic send_msg(input midi_pkg::port_t port, input midi_pkg::midi_byte_t status,
                            input midi_pkg::midi_byte_t d1, input midi_pkg::midi_byte_t d2);
        midi_pkg::midi_msg_t m;
        int len;
        len = expected_len(status);
        m.status = status;
        m.data1 = (len >= 1) ? d1 : 8'h00;
        m.data2 = (len == 2) ? d2 : 8'h00;
        if (port == 1'b0) exp_q0.push_back(m);
        else exp_q1.push_back(m);
        send_byte(port, status);
        if (len >= 1) send_byte(port, d1);
        if (len == 2) send_byte(port, d2);
    endtask

    task automatic wait_drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk);
    endtask

    task automatic wait_for_event();
        do @(negedge clk); while (!event_valid);
    endtask

    // --------------------
    // Monitor and timeout
    // --------------------
    always @(negedge clk) begin
        if (!reset && event_valid) begin
            event_count++;
            if (event_out.port == 1'b0 && exp_q0.size() == 0) begin
                $display("unexpected event from port 0 at %0t", $time);
                failure_count++;
            end else if (event_out.port == 1'b1 && exp_q1.size() == 0) begin
                $display("unexpected event from port 1 at %0t", $time);
                failure_count++;
            end else begin
                expected_msg = (event_out.port == 1'b0) ? exp_q0.pop_front() : exp_q1.pop_front();
                check_value(event_out.msg, expected_msg, "event message");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped producing events", cycle_count);
            report_counts();
            $display("tests failed");
            $finish;
        end
    end

    // --------------------
    // Tests
    // --------------------
    task automatic idle_quiet_test();
        repeat (200) begin
            @(negedge clk);
            check_value(event_valid, 0, "event_valid on idle lines");
        end
    endtask

    task automatic note_on_test();
        send_msg(1'b0, 8'h90, 8'h3C, 8'h64);
        wait_drain();
    endtask

    // Port 1 served last, so port 0 leads the contention test
    task automatic short_msg_test();
        send_msg(1'b0, 8'hF6, 8'h00, 8'h00);
        wait_drain();
        send_msg(1'b1, 8'hC5, 8'h2A, 8'h00);
        wait_drain();
    endtask

    task automatic contention_test();
        int start_count;
        start_count = event_count;
        fork
            send_msg(1'b0, 8'h90, 8'h3C, 8'h64);
            send_msg(1'b1, 8'h91, 8'h40, 8'h50);
            begin
                wait_for_event();
                check_value(event_out.port, 0, "first port under contention");
                @(negedge clk);
                check_value(event_valid, 1, "second event on next cycle");
                check_value(event_out.port, 1, "second port under contention");
            end
        join
        wait_drain();
        repeat (50) @(negedge clk);
        check_value(event_count - start_count, 2, "event count under contention");
    endtask

    task automatic mixed_stream_test();
        midi_pkg::midi_byte_t status;
        for (int i = 0; i < 10; i++) begin
            case (i % 3)
                0:       status = 8'hF6;                  // 1 byte
                1:       status = {4'hC, 4'(take_bits(4))};
                default: status = {4'h9, 4'(take_bits(4))};
            endcase
            send_msg(midi_pkg::port_t'(i % 2), status, take_bits(7), take_bits(7));
        end
        wait_drain();
    endtask

    initial begin
        reset = 1'b1;
        midi_in0 = 1'b1;
        midi_in1 = 1'b1;
        mismatch_count = 0;
        failure_count = 0;
        event_count = 0;
        cycle_count = 0;
        lfsr_state = 32'd67705;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        idle_quiet_test();
        note_on_test();
        short_msg_test();
        contention_test();
        mixed_stream_test();

        repeat (400) @(negedge clk);
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            $display("events still expected at end: %0d on port 0, %0d on port 1",
                     exp_q0.size(), exp_q1.size());
            failure_count++;
        end
        report_counts();
        if (mismatch_count == 0 && failure_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/midi_merge_top.sv
`timescale 1ns/10ps
`default_nettype none

module midi_merge_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   midi_in0,
    input  wire                   midi_in1,
    output logic                  event_valid,
    output midi_pkg::midi_event_t event_out
);

    logic                 byte_ready0;
    logic                 byte_ready1;
    midi_pkg::midi_byte_t rx_byte0;
    midi_pkg::midi_byte_t rx_byte1;
    logic                 new_msg0;
    logic                 new_msg1;
    midi_pkg::midi_msg_t  msg0;
    midi_pkg::midi_msg_t  msg1;

    // --------------------
    // Receive paths
    // --------------------
    midi_uart_rx u_rx0 (.clk(clk), .reset(reset), .rx(midi_in0),
                        .byte_ready(byte_ready0), .rx_byte(rx_byte0));

    midi_msg_capture u_capture0 (.clk(clk), .reset(reset), .byte_ready(byte_ready0),
                                 .rx_byte(rx_byte0), .new_msg(new_msg0), .msg(msg0));

    midi_uart_rx u_rx1 (.clk(clk), .reset(reset), .rx(midi_in1),
                        .byte_ready(byte_ready1), .rx_byte(rx_byte1));

    midi_msg_capture u_capture1 (.clk(clk), .reset(reset), .byte_ready(byte_ready1),
                                 .rx_byte(rx_byte1), .new_msg(new_msg1), .msg(msg1));

    // Tagged single stream
    midi_msg_merge u_merge (
        .clk         (clk),
        .reset       (reset),
        .new_msg0    (new_msg0),
        .msg0        (msg0),
        .new_msg1    (new_msg1),
        .msg1        (msg1),
        .event_valid (event_valid),
        .event_out   (event_out)
    );

endmodule

`default_nettype wire

//--- hdl/midi_msg_merge.sv
`timescale 1ns/10ps
`default_nettype none

module midi_msg_merge (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   new_msg0,
    input  midi_pkg::midi_msg_t   msg0,
    input  wire                   new_msg1,
    input  midi_pkg::midi_msg_t   msg1,
    output logic                  event_valid,
    output midi_pkg::midi_event_t event_out
);

    logic                pending0;
    logic                pending1;
    midi_pkg::midi_msg_t hold0;
    midi_pkg::midi_msg_t hold1;
    midi_pkg::port_t     last_served;
    logic                req0;
    logic                req1;
    midi_pkg::port_t     sel;
    midi_pkg::midi_msg_t cur0;
    midi_pkg::midi_msg_t cur1;
    logic                grant0;
    logic                grant1;

    // --------------------
    // Arbitration
    // --------------------
    always_comb begin
        req0 = pending0 | new_msg0;     // Fresh message bypasses the slot
        req1 = pending1 | new_msg1;
        cur0 = pending0 ? hold0 : msg0;
        cur1 = pending1 ? hold1 : msg1;
        if (req0 && req1)
            sel = ~last_served;         // Alternate under contention
        else
            sel = midi_pkg::port_t'(req1);
        grant0 = req0 && (sel == midi_pkg::port_t'(0));
        grant1 = req1 && (sel == midi_pkg::port_t'(1));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending0    <= 1'b0;
            pending1    <= 1'b0;
            last_served <= midi_pkg::port_t'(1);  // Port 0 wins first
            event_valid <= 1'b0;
        end else begin
            pending0    <= req0 & ~grant0;
            pending1    <= req1 & ~grant1;
            event_valid <= req0 | req1;
            if (req0 || req1) last_served <= sel;
        end
    end

    always_ff @(posedge clk) begin
        if (new_msg0) hold0 <= msg0;
        if (new_msg1) hold1 <= msg1;
        if (req0 || req1) begin
            event_out.port <= sel;
            event_out.msg  <= grant1 ? cur1 : cur0;
        end
    end

    // Serial rate keeps each slot from overflowing
    a_no_overrun0: assert property (@(posedge clk) disable iff (reset)
        new_msg0 |-> !pending0);
    a_no_overrun1: assert property (@(posedge clk) disable iff (reset)
        new_msg1 |-> !pending1);

endmodule

`default_nettype wire

//--- hdl/midi_msg_capture.sv
`timescale 1ns/10ps
`default_nettype none

module midi_msg_capture (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  byte_ready,
    input  midi_pkg::midi_byte_t rx_byte,
    output logic                 new_msg,
    output midi_pkg::midi_msg_t  msg
);

    midi_pkg::capture_state_t state;
    midi_pkg::capture_state_t next_state;
    midi_pkg::midi_msg_t      msg_next;
    midi_pkg::data_len_t      data_len;

    // Length of the stored status byte, valid in cap_one
    midi_data_len_lookup u_len_lookup (
        .clk     (clk),
        .command (msg.status),
        .len     (data_len)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= midi_pkg::cap_idle;
            msg   <= '0;
        end else begin
            state <= next_state;
            msg   <= msg_next;
        end
    end

    // --------------------
    // Capture FSM
    // --------------------
    always_comb begin
        next_state = state;
        msg_next   = msg;
        case (state)
            midi_pkg::cap_idle: begin
                // First byte taken as status
                if (byte_ready) begin
                    msg_next        = '0;
                    msg_next.status = rx_byte;
                    next_state      = midi_pkg::cap_delay1;
                end
            end
            midi_pkg::cap_delay1: next_state = midi_pkg::cap_one;  // Lookup latency
            midi_pkg::cap_one: begin
                if (data_len == midi_pkg::data_len_t'(0)) begin
                    next_state = midi_pkg::cap_done;
                end else if (byte_ready) begin
                    msg_next.data1 = rx_byte;
                    if (data_len == midi_pkg::data_len_t'(1))
                        next_state = midi_pkg::cap_done;
                    else
                        next_state = midi_pkg::cap_delay2;
                end
            end
            midi_pkg::cap_delay2: next_state = midi_pkg::cap_two;
            midi_pkg::cap_two: begin
                if (byte_ready) begin
                    msg_next.data2 = rx_byte;
                    next_state     = midi_pkg::cap_done;
                end
            end
            midi_pkg::cap_done: next_state = midi_pkg::cap_idle;
            default:            next_state = midi_pkg::cap_idle;
        endcase
    end

    assign new_msg = (state == midi_pkg::cap_done);

    a_msg_pulse: assert property (@(posedge clk) disable iff (reset)
        new_msg |=> !new_msg);

endmodule

`default_nettype wire

//--- hdl/midi_data_len_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module midi_data_len_lookup (
    input  wire                  clk,
    input  midi_pkg::midi_byte_t command,
    output midi_pkg::data_len_t  len
);

    // One cycle from command to len
    always_ff @(posedge clk) begin
        case (command[7:4])
            4'h8, 4'h9, 4'hA, 4'hB, 4'hE: len <= midi_pkg::data_len_t'(2);
            4'hC, 4'hD:                   len <= midi_pkg::data_len_t'(1);
            4'hF: begin
                // System common
                case (command[3:0])
                    4'h2:       len <= midi_pkg::data_len_t'(2);   // Song position
                    4'h1, 4'h3: len <= midi_pkg::data_len_t'(1);
                    default:    len <= midi_pkg::data_len_t'(0);
                endcase
            end
            default: len <= midi_pkg::data_len_t'(0);
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/midi_uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_params.svh"

module midi_uart_rx (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  rx,
    output logic                 byte_ready,
    output midi_pkg::midi_byte_t rx_byte
);

    localparam int unsigned CNT_W = $clog2(`MIDI_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`MIDI_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`MIDI_CLKS_PER_BIT - 1);

    logic                 rx_meta;
    logic                 rx_sync;
    midi_pkg::rx_state_t  state;
    logic [CNT_W-1:0]     bit_cnt;
    logic [2:0]           bit_idx;
    midi_pkg::midi_byte_t shift_reg;

    // Line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // --------------------
    // Frame FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= midi_pkg::rx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            byte_ready <= 1'b0;
        end else begin
            byte_ready <= 1'b0;
            bit_cnt    <= bit_cnt + 1'b1;
            case (state)
                midi_pkg::rx_idle: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= midi_pkg::rx_start;
                end
                midi_pkg::rx_start: if (bit_cnt == HALF_BIT) begin
                    bit_cnt <= '0;
                    state   <= rx_sync ? midi_pkg::rx_idle : midi_pkg::rx_data;  // Glitch check
                end
                midi_pkg::rx_data: if (bit_cnt == FULL_BIT) begin
                    bit_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= midi_pkg::rx_stop;
                end
                default: if (bit_cnt == FULL_BIT) begin
                    state      <= midi_pkg::rx_idle;
                    byte_ready <= rx_sync;      // Bad stop bit drops the byte
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == midi_pkg::rx_data && bit_cnt == FULL_BIT)
            shift_reg <= {rx_sync, shift_reg[7:1]};
    end

    assign rx_byte = shift_reg;

    a_single_strobe: assert property (@(posedge clk) disable iff (reset)
        byte_ready |=> !byte_ready);

endmodule

`default_nettype wire

//--- hdl/midi_pkg.sv
`default_nettype none

package midi_pkg;

    `include "midi_params.svh"

    typedef logic [7:0] midi_byte_t;
    typedef logic [1:0] data_len_t;     // Data bytes after status, 0 to 2
    typedef logic [$clog2(`MIDI_NUM_PORTS)-1:0] port_t;

    // Unused data bytes stay zero
    typedef struct packed {
        midi_byte_t data2;
        midi_byte_t data1;
        midi_byte_t status;
    } midi_msg_t;

    typedef struct packed {
        port_t     port;
        midi_msg_t msg;
    } midi_event_t;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    typedef enum logic [2:0] {
        cap_idle, cap_delay1, cap_one, cap_delay2, cap_two, cap_done
    } capture_state_t;

endpackage

`default_nettype wire

//--- hdl/midi_params.svh
`ifndef MIDI_PARAMS_SVH
`define MIDI_PARAMS_SVH

// --------------------
// Serial timing
// --------------------

// 31250 baud from a 1 MHz clock
`define MIDI_CLKS_PER_BIT 32

// --------------------
// Merge
// --------------------

`define MIDI_NUM_PORTS 2    // Sets the port tag width

`endif
